//--- verilog/matmul_pkg.sv
`default_nettype none

package matmul_pkg;

  // element width and full precision sum width
  localparam int data_w = 16;
  localparam int acc_w = 2 * data_w;

  // square array so one lane per row and per column
  localparam int array_n = 4;

  // operand memory of 128 words
  localparam int addr_w = 7;

  typedef logic [data_w-1:0] data_t;
  typedef logic [acc_w-1:0] acc_t;
  // lane 0 sits in the low bits
  typedef logic [array_n-1:0][data_w-1:0] lane_vec_t;
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [4:0] cnt_t;

  // parked on the last word while not fetching
  localparam addr_t addr_idle = addr_t'(2 ** addr_w - 1);
  // four words per operand plus fill and drain
  localparam cnt_t done_cnt = cnt_t'(4 * array_n - 2 + 4);
  // row 0 grabs its results here and row i follows i cycles later
  localparam cnt_t latch_base = cnt_t'(array_n + 7);

endpackage

`default_nettype wire

//--- verilog/processing_element.sv
`timescale 1ns/1ps
`default_nettype none

// one cell of the output-stationary grid
module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              run,
  input  matmul_pkg::data_t in_a,
  input  matmul_pkg::data_t in_b,
  output matmul_pkg::data_t out_a,
  output matmul_pkg::data_t out_b,
  output matmul_pkg::data_t out_c
);

  // running sum kept at full precision
  matmul_pkg::acc_t acc;
  matmul_pkg::acc_t product;

  // unsigned multiply, operands widened first
  assign product = matmul_pkg::acc_t'(in_a) * matmul_pkg::acc_t'(in_b);

  // operands step one cell right and one cell down per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // sum restarts whenever no run is active
  always_ff @(posedge clk) begin
    if (reset || !run) begin
      acc <= '0;
    end else begin
      acc <= acc + product;
    end
  end

  // clip to all ones once anything lands in the upper half
  assign out_c = (|acc[matmul_pkg::acc_w-1:matmul_pkg::data_w]) ?
                 '1 : acc[matmul_pkg::data_w-1:0];

endmodule

`default_nettype wire

//--- verilog/systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

// 4x4 grid of PEs, a flows right and b flows down
module systolic_array (
  input  logic                                            clk,
  input  logic                                            reset,
  input  logic                                            run,
  input  matmul_pkg::lane_vec_t                           a_in,
  input  matmul_pkg::lane_vec_t                           b_in,
  output matmul_pkg::lane_vec_t [matmul_pkg::array_n-1:0] c_matrix
);

  // a_link[i][j] enters pe(i,j) from the left
  // last column is the right edge and goes nowhere
  matmul_pkg::data_t a_link [matmul_pkg::array_n][matmul_pkg::array_n+1];
  // b_link[i][j] enters pe(i,j) from above
  matmul_pkg::data_t b_link [matmul_pkg::array_n+1][matmul_pkg::array_n];

  // left edge from the a skew
  for (genvar i = 0; i < matmul_pkg::array_n; i++) begin : g_left
    assign a_link[i][0] = a_in[i];
  end

  // top edge from the b skew
  for (genvar j = 0; j < matmul_pkg::array_n; j++) begin : g_top
    assign b_link[0][j] = b_in[j];
  end

  for (genvar i = 0; i < matmul_pkg::array_n; i++) begin : g_row
    for (genvar j = 0; j < matmul_pkg::array_n; j++) begin : g_col
      // result of pe(i,j) is element c[i][j]
      processing_element u_pe (
        .clk   (clk),
        .reset (reset),
        .run   (run),
        .in_a  (a_link[i][j]),
        .in_b  (b_link[i][j]),
        .out_a (a_link[i][j+1]),
        .out_b (b_link[i+1][j]),
        .out_c (c_matrix[i][j])
      );
    end
  end

endmodule

`default_nettype wire

//--- verilog/input_skew.sv
`timescale 1ns/1ps
`default_nettype none

// staircase delay so lane i enters the grid i cycles late
module input_skew (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clear,
  input  matmul_pkg::lane_vec_t data_in,
  output matmul_pkg::lane_vec_t data_out
);

  // lane 0 goes straight through
  assign data_out[0] = data_in[0];

  for (genvar lane = 1; lane < matmul_pkg::array_n; lane++) begin : g_lane
    // one register per cycle of delay
    matmul_pkg::data_t dly [lane];

    always_ff @(posedge clk) begin
      if (reset || clear) begin
        // flush leftovers from an earlier run
        for (int s = 0; s < lane; s++) begin
          dly[s] <= '0;
        end
      end else begin
        dly[0] <= data_in[lane];
        for (int s = 1; s < lane; s++) begin
          dly[s] <= dly[s-1];
        end
      end
    end

    // oldest stage drives the lane
    assign data_out[lane] = dly[lane-1];
  end

endmodule

`default_nettype wire

//--- verilog/run_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// run control for one stand-alone tile
module run_sequencer (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            start_mat_mul,
  output matmul_pkg::addr_t               a_addr,
  output matmul_pkg::addr_t               b_addr,
  output logic                            skew_clear,
  output logic [matmul_pkg::array_n-1:0]  row_latch,
  output logic                            done_mat_mul
);

  // cycles since start was first seen high
  matmul_pkg::cnt_t  cnt;
  // shared by both operand streams at tile position zero
  matmul_pkg::addr_t fetch_addr;

  // counter freezes at the terminal count once done is up
  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      cnt          <= '0;
      done_mat_mul <= 1'b0;
    end else if (cnt == matmul_pkg::done_cnt) begin
      done_mat_mul <= 1'b1;
    end else if (!done_mat_mul) begin
      cnt <= cnt + 1'b1;
    end
  end

  // idle address wraps to 0, then steps up to 3
  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      fetch_addr <= matmul_pkg::addr_idle;
    end else if (cnt < matmul_pkg::cnt_t'(matmul_pkg::array_n)) begin
      fetch_addr <= fetch_addr + 1'b1;
    end else begin
      fetch_addr <= matmul_pkg::addr_idle;
    end
  end

  assign a_addr = fetch_addr;
  assign b_addr = fetch_addr;

  // skew lines stay empty until the first word is on its way
  assign skew_clear = !start_mat_mul || (cnt == '0);

  // one row grabbed per cycle, row 0 first
  always_comb begin
    for (int r = 0; r < matmul_pkg::array_n; r++) begin
      row_latch[r] = (cnt == matmul_pkg::latch_base + matmul_pkg::cnt_t'(r));
    end
  end

  // done only ever sits at the terminal count
  a_done_cnt: assert property (@(posedge clk) disable iff (reset)
    done_mat_mul |-> (cnt == matmul_pkg::done_cnt));
  // fetches stay inside the operand window or parked
  a_addr_range: assert property (@(posedge clk) disable iff (reset)
    (fetch_addr < matmul_pkg::addr_t'(matmul_pkg::array_n)) ||
    (fetch_addr == matmul_pkg::addr_idle));
  a_latch_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(row_latch));

endmodule

`default_nettype wire

//--- verilog/result_drain.sv
`timescale 1ns/1ps
`default_nettype none

// per row shift register that serializes a finished row onto one lane
module result_drain (
  input  logic                                            clk,
  input  logic                                            reset,
  input  logic [matmul_pkg::array_n-1:0]                  row_latch,
  input  matmul_pkg::lane_vec_t [matmul_pkg::array_n-1:0] c_matrix,
  output matmul_pkg::lane_vec_t                           c_data_out
);

  for (genvar r = 0; r < matmul_pkg::array_n; r++) begin : g_row
    // element 0 is the one on the output lane
    matmul_pkg::lane_vec_t row_q;

    always_ff @(posedge clk) begin
      if (reset) begin
        row_q <= '0;
      end else if (row_latch[r]) begin
        // whole row from the grid, c[r][0] lands lowest
        row_q <= c_matrix[r];
      end else begin
        // step down one element, zero fills from the top
        row_q <= {matmul_pkg::data_t'(0), row_q[matmul_pkg::array_n-1:1]};
      end
    end

    // lane r carries row r, one column per cycle
    assign c_data_out[r] = row_q[0];

    // a second latch right behind the first would drop three columns
    a_single_latch: assert property (@(posedge clk) disable iff (reset)
      row_latch[r] |=> !row_latch[r]);
  end

endmodule

`default_nettype wire

//--- verilog/matmul_4x4_systolic.sv
`timescale 1ns/1ps
`default_nettype none

// stand-alone 4x4 systolic matrix multiplier, C = A x B
module matmul_4x4_systolic (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start_mat_mul,
  input  matmul_pkg::lane_vec_t a_data,
  input  matmul_pkg::lane_vec_t b_data,
  output matmul_pkg::addr_t     a_addr,
  output matmul_pkg::addr_t     b_addr,
  output matmul_pkg::lane_vec_t c_data_out,
  output logic                  done_mat_mul
);

  logic                                            skew_clear;
  logic [matmul_pkg::array_n-1:0]                  row_latch;
  matmul_pkg::lane_vec_t                           a_skewed;
  matmul_pkg::lane_vec_t                           b_skewed;
  matmul_pkg::lane_vec_t [matmul_pkg::array_n-1:0] c_matrix;

  run_sequencer u_sequencer (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .a_addr        (a_addr),
    .b_addr        (b_addr),
    .skew_clear    (skew_clear),
    .row_latch     (row_latch),
    .done_mat_mul  (done_mat_mul)
  );

  // a word k is column k of A, lane i goes to grid row i
  input_skew a_skew (
    .clk      (clk),
    .reset    (reset),
    .clear    (skew_clear),
    .data_in  (a_data),
    .data_out (a_skewed)
  );

  // b word k is row k of B, lane j goes to grid column j
  input_skew b_skew (
    .clk      (clk),
    .reset    (reset),
    .clear    (skew_clear),
    .data_in  (b_data),
    .data_out (b_skewed)
  );

  // accumulators only run while start is held
  systolic_array u_array (
    .clk      (clk),
    .reset    (reset),
    .run      (start_mat_mul),
    .a_in     (a_skewed),
    .b_in     (b_skewed),
    .c_matrix (c_matrix)
  );

  result_drain u_drain (
    .clk        (clk),
    .reset      (reset),
    .row_latch  (row_latch),
    .c_matrix   (c_matrix),
    .c_data_out (c_data_out)
  );

endmodule

`default_nettype wire

//--- sim/tb_matmul.sv
`timescale 1ns/1ps
`default_nettype none

// directed tests for the stand-alone 4x4 systolic multiplier
module tb_matmul;

  localparam int n = matmul_pkg::array_n;
  // port timing counted in edges with start high
  localparam int fetch_edges = 4;
  localparam int first_out_edge = 12;
  localparam int run_edges = 19;
  // twice the length of seven runs of at most 25 cycles plus reset
  localparam int timeout_cycles = 2 * (4 + 7 * 25);

  logic                  clk = 1'b0;
  logic                  reset = 1'b1;
  logic                  start_mat_mul = 1'b0;
  matmul_pkg::lane_vec_t a_data = '0;
  matmul_pkg::lane_vec_t b_data = '0;
  matmul_pkg::addr_t     a_addr;
  matmul_pkg::addr_t     b_addr;
  matmul_pkg::lane_vec_t c_data_out;
  logic                  done_mat_mul;

  // operands, memory images and captured result
  matmul_pkg::data_t     mat_a [n][n];
  matmul_pkg::data_t     mat_b [n][n];
  matmul_pkg::lane_vec_t a_mem [n];
  matmul_pkg::lane_vec_t b_mem [n];
  matmul_pkg::data_t     result [n][n];
  logic [31:0]           rng = 32'd76;
  int                    cycle_count = 0;

  always #50 clk = ~clk;

  matmul_4x4_systolic dut (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .a_data        (a_data),
    .b_data        (b_data),
    .a_addr        (a_addr),
    .b_addr        (b_addr),
    .c_data_out    (c_data_out),
    .done_mat_mul  (done_mat_mul)
  );

  // both memories with a one-cycle read and zero outside words 0..3
  always @(posedge clk) begin
    a_data <= (a_addr < matmul_pkg::addr_t'(n)) ? a_mem[a_addr[1:0]] : '0;
    b_data <= (b_addr < matmul_pkg::addr_t'(n)) ? b_mem[b_addr[1:0]] : '0;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      stop_on_error($sformatf("Timeout: tests still running after %0d cycles", cycle_count));
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_data(input string what, input matmul_pkg::data_t expected,
                              input matmul_pkg::data_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Mismatch at %0t ns: %s expected %h got %h",
                              $time, what, expected, actual));
    end
  endtask

  task automatic compare_addr(input string what, input matmul_pkg::addr_t expected,
                              input matmul_pkg::addr_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Mismatch at %0t ns: %s expected %0d got %0d",
                              $time, what, expected, actual));
    end
  endtask

  task automatic compare_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Mismatch at %0t ns: %s expected %b got %b",
                              $time, what, expected, actual));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // masked pseudo random values for both operands
  task automatic fill_random(input matmul_pkg::data_t mask);
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        rng = xorshift(rng);
        mat_a[i][j] = rng[15:0] & mask;
        rng = xorshift(rng);
        mat_b[i][j] = rng[31:16] & mask;
      end
    end
  endtask

  // C[i][j] as a wrapping 32-bit sum that clips when the upper half is set
  function automatic matmul_pkg::data_t expected_elem(input int i, input int j);
    logic [31:0] sum;
    sum = '0;
    for (int k = 0; k < n; k++) begin
      sum = sum + 32'(mat_a[i][k]) * 32'(mat_b[k][j]);
    end
    return (sum[31:16] != '0) ? 16'hFFFF : sum[15:0];
  endfunction

  task automatic check_fetch(input int e);
    matmul_pkg::addr_t expected;
    expected = (e >= 1 && e <= fetch_edges) ? matmul_pkg::addr_t'(e - 1)
                                            : matmul_pkg::addr_idle;
    compare_addr($sformatf("a_addr after edge %0d", e), expected, a_addr);
    compare_addr($sformatf("b_addr after edge %0d", e), expected, b_addr);
  endtask

  // one full run with addresses, done and idle lanes checked on every edge
  task automatic run_mult(input int hold);
    int j;
    // word k of A is column k and word k of B is row k
    for (int k = 0; k < n; k++) begin
      for (int i = 0; i < n; i++) begin
        a_mem[k][i] = mat_a[i][k];
        b_mem[k][i] = mat_b[k][i];
      end
    end
    @(posedge clk);
    start_mat_mul <= 1'b1;
    @(negedge clk);
    compare_bit("done with start low", 1'b0, done_mat_mul);
    check_fetch(0);
    for (int e = 1; e <= run_edges; e++) begin
      @(posedge clk);
      @(negedge clk);
      check_fetch(e);
      compare_bit($sformatf("done after edge %0d", e), e == run_edges, done_mat_mul);
      // lane i shows C[i][j] right after edge 12+i+j
      for (int i = 0; i < n; i++) begin
        j = e - first_out_edge - i;
        if (j >= 0 && j < n) begin
          result[i][j] = c_data_out[i];
        end else begin
          compare_data($sformatf("idle lane %0d after edge %0d", i, e), '0, c_data_out[i]);
        end
      end
    end
    for (int h = 0; h < hold; h++) begin
      @(posedge clk);
      @(negedge clk);
      compare_bit("done while start held", 1'b1, done_mat_mul);
    end
    // this edge still samples start high
    @(posedge clk);
    start_mat_mul <= 1'b0;
    @(negedge clk);
    compare_bit("done on last high edge", 1'b1, done_mat_mul);
  endtask

  task automatic check_product(input string name);
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        compare_data($sformatf("%s c[%0d][%0d]", name, i, j), expected_elem(i, j),
                     result[i][j]);
      end
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    compare_bit("done after reset", 1'b0, done_mat_mul);
    check_fetch(0);
    for (int i = 0; i < n; i++) begin
      compare_data($sformatf("reset lane %0d", i), '0, c_data_out[i]);
    end
  endtask

  task automatic test_timing();
    fill_random(16'h00FF);
    run_mult(3);
    check_product("timing");
  endtask

  // identity A passes B straight through
  task automatic test_identity();
    fill_random(16'hFFFF);
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        mat_a[i][j] = (i == j) ? 16'd1 : 16'd0;
      end
    end
    run_mult(0);
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        compare_data($sformatf("identity c[%0d][%0d]", i, j), mat_b[i][j], result[i][j]);
      end
    end
  endtask

  task automatic test_random();
    fill_random(16'h00FF);
    run_mult(0);
    check_product("random");
  endtask

  task automatic test_saturation();
    fill_random(16'h00FF);
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        mat_a[i][j] = 16'hFFFF - mat_a[i][j];
        mat_b[i][j] = 16'hFFFF - mat_b[i][j];
      end
    end
    run_mult(0);
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        compare_data($sformatf("full sat c[%0d][%0d]", i, j), 16'hFFFF, result[i][j]);
      end
    end
    // 9-bit rows 0 and 1 of A and columns 0 and 1 of B with small values elsewhere
    // so only the top left 2x2 block clips
    fill_random(16'h000F);
    for (int i = 0; i < 2; i++) begin
      for (int k = 0; k < n; k++) begin
        mat_a[i][k] = 16'h0100 | (mat_a[i][k] << 4);
        mat_b[k][i] = 16'h0100 | (mat_b[k][i] << 4);
      end
    end
    run_mult(0);
    check_product("mixed sat");
  endtask

  // start low for a single edge between two runs and no reset in between
  task automatic test_back_to_back();
    fill_random(16'h00FF);
    run_mult(0);
    check_product("first of pair");
    fill_random(16'h00FF);
    run_mult(0);
    check_product("second of pair");
  endtask

  initial begin
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_timing();
    test_identity();
    test_random();
    test_saturation();
    test_back_to_back();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
verilog/matmul_pkg.sv
verilog/processing_element.sv
verilog/systolic_array.sv
verilog/input_skew.sv
verilog/run_sequencer.sv
verilog/result_drain.sv
verilog/matmul_4x4_systolic.sv
sim/tb_matmul.sv

//--- run_sim.sh
#!/bin/sh
# build the systolic multiplier testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_matmul \
  -f files.f -o sim_matmul
./obj_dir/sim_matmul > sim.log 2>&1 || true
cat sim.log
if grep -qx "TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
